// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary -sv -j 0
TOP       ?= mem_wb_tb
FILELIST  ?= mem_wb.f
BUILD     ?= obj_dir
LOG       ?= sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) hw/mem_pipe_defines.svh
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "no result in log"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/mem_wb_tb.sv ====
// testbench for the memory back end with stimulus, reference model,
// compare process and watchdog
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module mem_wb_tb;
    import mem_pipe_pkg::*;

    localparam int clk_period    = 40;
    // valid requests per test, the random mix counted at two per step
    localparam int max_reqs      = 2 * `MP_DMEM_WORDS + 16 * 12 + 16 * 14 + 48 + 2 * 200;
    localparam int margin_cycles = 500;

    logic                clk = 1'b0;
    logic                rst;
    logic                move;
    logic                in_valid;
    logic [4:0]          in_rd;
    logic [2:0]          in_funct3;
    logic                in_mem_we;
    logic                in_mem_re;
    logic                in_reg_we;
    logic [`MP_XLEN-1:0] in_alu_out;
    logic [`MP_XLEN-1:0] in_rs2_v;
    logic                wb_valid;
    logic                wb_we;
    logic [4:0]          wb_rd;
    logic [`MP_XLEN-1:0] wb_data;

    // expected entry is {we, rd, data}
    logic [`MP_XLEN-1:0] mirror [`MP_DMEM_WORDS];
    logic [`MP_XLEN+5:0] exp_q [$];
    logic                adv = 1'b0;
    integer              seed = 32'h4eb3;
    int                  errors = 0;
    int                  checks = 0;
    int                  requests = 0;
    int                  err_mark = 0;

    mem_wb_top u_mem_wb_top (
        .clk(clk), .rst(rst), .move(move), .in_valid(in_valid), .in_rd(in_rd),
        .in_funct3(in_funct3), .in_mem_we(in_mem_we), .in_mem_re(in_mem_re),
        .in_reg_we(in_reg_we), .in_alu_out(in_alu_out), .in_rs2_v(in_rs2_v),
        .wb_valid(wb_valid), .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] rnd();
        rnd = $random(seed);
    endfunction

    function automatic logic [31:0] addr_of(input logic [7:0] idx, input logic [1:0] off);
        return {22'h0, idx, off};
    endfunction

    // natural alignment from the access size in funct3
    function automatic logic [31:0] align(input logic [31:0] a, input logic [2:0] f3);
        logic [31:0] r;
        r = a;
        if (f3[1:0] == 2'b01) r[0] = 1'b0;
        if (f3[1]) r[1:0] = 2'b00;
        return r;
    endfunction

    // expected writeback from the mirror before this request's own store
    function automatic logic [`MP_XLEN+5:0] ref_wb(input logic [4:0] rd, input logic [2:0] f3,
                                                   input logic re, input logic rwe,
                                                   input logic [31:0] alu);
        logic [31:0] word;
        logic [31:0] lanes;
        logic [31:0] data;
        word  = mirror[alu[`MP_DMEM_AW+1:2]];
        lanes = word >> (8 * alu[1:0]);
        data  = alu;
        if (re) begin
            case (f3)
                load_f3_lb:  data = {{24{lanes[7]}}, lanes[7:0]};
                load_f3_lbu: data = {24'h0, lanes[7:0]};
                load_f3_lh:  data = {{16{lanes[15]}}, lanes[15:0]};
                load_f3_lhu: data = {16'h0, lanes[15:0]};
                default:     data = word;
            endcase
        end
        return {rwe, rd, data};
    endfunction

    task automatic store_mirror(input logic [2:0] f3, input logic [31:0] alu,
                                input logic [31:0] rs2);
        logic [31:0] mask;
        int          shift;
        shift = 8 * alu[1:0];
        case (f3)
            store_f3_sb: mask = 32'h0000_00ff;
            store_f3_sh: mask = 32'h0000_ffff;
            default:     mask = 32'hffff_ffff;
        endcase
        mirror[alu[`MP_DMEM_AW+1:2]] = (mirror[alu[`MP_DMEM_AW+1:2]] & ~(mask << shift))
                                     | ((rs2 & mask) << shift);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // holds the request until an edge with move high takes it
    task automatic send_req(input logic v, input logic [4:0] rd, input logic [2:0] f3,
                            input logic we, input logic re, input logic rwe,
                            input logic [31:0] alu, input logic [31:0] rs2, input int stall);
        logic        accepted;
        logic [31:0] r;
        accepted = 1'b0;
        in_valid   <= v;
        in_rd      <= rd;
        in_funct3  <= f3;
        in_mem_we  <= we;
        in_mem_re  <= re;
        in_reg_we  <= rwe;
        in_alu_out <= alu;
        in_rs2_v   <= rs2;
        while (!accepted) begin
            r = rnd();
            move <= (r % 100) >= stall;
            @(posedge clk);
            accepted = move;
        end
    endtask

    task automatic store(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] d,
                         input int stall);
        logic [31:0] r;
        r = rnd();
        send_req(1'b1, r[4:0], f3, 1'b1, 1'b0, 1'b0, a, d, stall);
    endtask

    task automatic load(input logic [2:0] f3, input logic [31:0] a, input int stall);
        logic [31:0] r;
        r = rnd();
        send_req(1'b1, r[4:0], f3, 1'b0, 1'b1, 1'b1, a, r, stall);
    endtask

    // invalid slot with random fields and memory flags
    task automatic idle(input int stall);
        logic [31:0] r;
        r = rnd();
        send_req(1'b0, r[4:0], r[7:5], r[8], r[9], r[10], rnd(), rnd(), stall);
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) idle(0);
        idle(0);
        idle(0);
        $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    always @(posedge clk) begin
        if (!rst && move && in_valid) begin
            exp_q.push_back(ref_wb(in_rd, in_funct3, in_mem_re, in_reg_we, in_alu_out));
            if (in_mem_we) store_mirror(in_funct3, in_alu_out, in_rs2_v);
            requests++;
        end
        adv <= move;
    end

    always @(negedge clk) begin
        logic [`MP_XLEN+5:0] e;
        if (rst === 1'b1) begin
            if (wb_valid !== 1'b0) begin
                errors++;
                $display("wb_valid is not low during reset at %0t", $time);
            end
        end else if (adv && wb_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("writeback with no request outstanding at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                check("wb_we", {31'b0, wb_we}, {31'b0, e[`MP_XLEN+5]});
                check("wb_rd", {27'b0, wb_rd}, {27'b0, e[`MP_XLEN+4:`MP_XLEN]});
                check("wb_data", wb_data, e[`MP_XLEN-1:0]);
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [2:0]  f3;
        rst = 1'b1;
        move = 1'b0;
        in_valid = 1'b0;
        in_rd = '0;
        in_funct3 = '0;
        in_mem_we = 1'b0;
        in_mem_re = 1'b0;
        in_reg_we = 1'b0;
        in_alu_out = '0;
        in_rs2_v = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (8) idle(30);
        finish_test("reset_quiet");

        for (int i = 0; i < `MP_DMEM_WORDS; i++) begin
            a = addr_of(i[7:0], 2'b00);
            store(store_f3_sw, a, (a * 32'h9e37_79b1) ^ 32'h3c3c_3c3c, 0);
        end
        for (int i = 0; i < `MP_DMEM_WORDS; i++) load(load_f3_lw, addr_of(i[7:0], 2'b00), 0);
        finish_test("word_store_load");

        // word reload after every single store shows its lanes alone
        for (int n = 0; n < 16; n++) begin
            r = rnd();
            for (int o = 0; o < 4; o++) begin
                store(store_f3_sb, addr_of(r[7:0], o[1:0]), rnd(), 0);
                load(load_f3_lw, addr_of(r[7:0], 2'b00), 0);
            end
            for (int o = 0; o < 4; o += 2) begin
                store(store_f3_sh, addr_of(r[7:0], o[1:0]), rnd(), 0);
                load(load_f3_lw, addr_of(r[7:0], 2'b00), 0);
            end
        end
        finish_test("subword_store");

        for (int n = 0; n < 16; n++) begin
            r = rnd();
            store(store_f3_sw, addr_of(r[7:0], 2'b00), (n == 0) ? 32'h80ff_7f01 : rnd(), 0);
            for (int o = 0; o < 4; o++) begin
                load(load_f3_lb, addr_of(r[7:0], o[1:0]), 0);
                load(load_f3_lbu, addr_of(r[7:0], o[1:0]), 0);
            end
            for (int o = 0; o < 4; o += 2) begin
                load(load_f3_lh, addr_of(r[7:0], o[1:0]), 0);
                load(load_f3_lhu, addr_of(r[7:0], o[1:0]), 0);
            end
            load(load_f3_lw, addr_of(r[7:0], 2'b00), 0);
        end
        finish_test("load_extend");

        for (int n = 0; n < 32; n++) begin
            r = rnd();
            send_req(1'b1, r[4:0], r[7:5], 1'b0, 1'b0, r[8], rnd(), rnd(), 0);
            idle(0);
        end
        for (int n = 0; n < 16; n++) begin
            r = rnd();
            load(load_f3_lw, addr_of(r[7:0], 2'b00), 0);
        end
        finish_test("alu_and_invalid");

        // case 3 is a store with an immediate reload
        for (int n = 0; n < 200; n++) begin
            r = rnd();
            a = rnd();
            f3 = (r[9:8] == 2'b11) ? 3'b010 : {1'b0, r[9:8]};
            case (r % 5)
                0: send_req(1'b1, r[14:10], r[17:15], 1'b0, 1'b0, r[18], a, rnd(), 40);
                1: store(f3, align(a, f3), rnd(), 40);
                2: load((r[10:8] inside {3'b011, 3'b110, 3'b111}) ? 3'b010 : r[10:8],
                        align(a, r[10:8]), 40);
                3: begin
                    store(f3, align(a, f3), rnd(), 40);
                    load(load_f3_lw, align(a, 3'b010), 40);
                end
                default: idle(40);
            endcase
        end
        finish_test("random_stall");

        $display("requests %0d, checks %0d, errors %0d", requests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(clk_period * (max_reqs * 4 + margin_cycles));
        $display("run timed out with %0d writebacks still expected", exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hw/dmem_sram.sv ====
// word-organized data memory, byte write enables, registered read
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module dmem_sram (
    input  logic                  clk,
    input  logic                  req,
    input  logic [`MP_XLEN-1:0]   addr,
    input  logic [`MP_XLEN/8-1:0] wmask,
    input  logic [`MP_XLEN-1:0]   wdata,
    output logic [`MP_XLEN-1:0]   rdata
);

    logic [`MP_XLEN-1:0]   mem [`MP_DMEM_WORDS];
    logic [`MP_DMEM_AW-1:0] idx;
    logic                   rd_en;

    // word index from the address word bits
    assign idx   = addr[`MP_DMEM_AW+1:2];
    assign rd_en = req && (wmask == '0);

    always_ff @(posedge clk) begin
        if (req) begin
            for (int i = 0; i < `MP_XLEN/8; i++) begin
                if (wmask[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read data holds when there is no read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[idx];
        end
    end

endmodule

// ==== hw/load_align.sv ====
// writeback select: aligned and extended load data, or the alu result
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module load_align (
    input  logic                valid,
    input  logic [4:0]          rd,
    input  logic [2:0]          funct3,
    input  logic                mem_re,
    input  logic                reg_we,
    input  logic [`MP_XLEN-1:0] alu_out,
    input  logic [`MP_XLEN-1:0] rdata,
    output logic                wb_valid,
    output logic                wb_we,
    output logic [4:0]          wb_rd,
    output logic [`MP_XLEN-1:0] wb_data
);
    import mem_pipe_pkg::*;

    logic [1:0]  offset;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign offset   = alu_out[1:0];
    assign ld_byte  = rdata[8*offset +: 8];
    assign ld_half  = rdata[16*offset[1] +: 16];

    assign wb_valid = valid;
    assign wb_we    = valid && reg_we;
    assign wb_rd    = rd;

    always_comb begin
        wb_data = alu_out;
        if (mem_re) begin
            case (funct3)
                load_f3_lb:  wb_data = {{(`MP_XLEN-8){ld_byte[7]}}, ld_byte};
                load_f3_lbu: wb_data = {{(`MP_XLEN-8){1'b0}}, ld_byte};
                load_f3_lh:  wb_data = {{(`MP_XLEN-16){ld_half[15]}}, ld_half};
                load_f3_lhu: wb_data = {{(`MP_XLEN-16){1'b0}}, ld_half};
                load_f3_lw:  wb_data = rdata;
                default:     wb_data = rdata;
            endcase
        end
    end

endmodule

// ==== hw/mem_pipe_defines.svh ====
// width and depth macros for the memory back end
`ifndef MEM_PIPE_DEFINES_SVH
`define MEM_PIPE_DEFINES_SVH

// data and address width
`define MP_XLEN 32

// data memory depth in words
`define MP_DMEM_WORDS 256

// word index width, log2 of the depth
`define MP_DMEM_AW 8

`endif

// ==== hw/mem_pipe_pkg.sv ====
// funct3 encodings for loads and stores
// payload structs of the ex/mem and mem/wb stage registers
`include "mem_pipe_defines.svh"

package mem_pipe_pkg;

    typedef enum logic [2:0] {
        load_f3_lb  = 3'b000,
        load_f3_lh  = 3'b001,
        load_f3_lw  = 3'b010,
        load_f3_lbu = 3'b100,
        load_f3_lhu = 3'b101
    } load_f3_t;

    typedef enum logic [2:0] {
        store_f3_sb = 3'b000,
        store_f3_sh = 3'b001,
        store_f3_sw = 3'b010
    } store_f3_t;

    // execute result entering the memory stage
    typedef struct packed {
        logic [4:0]          rd;
        logic [2:0]          funct3;
        logic                mem_we;
        logic                mem_re;
        logic                reg_we;
        logic [`MP_XLEN-1:0] alu_out;
        logic [`MP_XLEN-1:0] rs2_v;
    } ex_mem_payload_t;

    // alu_out[1:0] is the byte offset used by load alignment
    typedef struct packed {
        logic [4:0]          rd;
        logic [2:0]          funct3;
        logic                mem_re;
        logic                reg_we;
        logic [`MP_XLEN-1:0] alu_out;
    } mem_wb_payload_t;

endpackage

// ==== hw/mem_stage.sv ====
// memory stage forming the aligned address, byte masks,
// lane-shifted store data and request strobe for the data memory
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module mem_stage (
    input  logic                  move,
    input  logic                  in_valid,
    input  logic [2:0]            funct3,
    input  logic                  mem_we,
    input  logic                  mem_re,
    input  logic [`MP_XLEN-1:0]   alu_out,
    input  logic [`MP_XLEN-1:0]   rs2_v,
    output logic                  dmem_req,
    output logic [`MP_XLEN-1:0]   dmem_addr,
    output logic [`MP_XLEN/8-1:0] dmem_rmask,
    output logic [`MP_XLEN/8-1:0] dmem_wmask,
    output logic [`MP_XLEN-1:0]   dmem_wdata,
    output logic                  out_valid
);
    import mem_pipe_pkg::*;

    logic [1:0] offset;
    logic       active;

    assign offset    = alu_out[1:0];
    assign active    = in_valid && move;
    assign out_valid = active;

    // word aligned address, low bits cleared
    always_comb begin
        dmem_addr       = alu_out;
        dmem_addr[1:0]  = 2'b00;
    end

    always_comb begin
        dmem_req   = 1'b0;
        dmem_wmask = '0;
        dmem_rmask = '0;
        dmem_wdata = '0;
        if (active) begin
            // store mask and data shifted into the addressed lanes
            if (mem_we) begin
                dmem_req = 1'b1;
                case (funct3)
                    store_f3_sb: begin
                        dmem_wmask = 4'b0001 << offset;
                        dmem_wdata[8*offset +: 8] = rs2_v[7:0];
                    end
                    store_f3_sh: begin
                        dmem_wmask = 4'b0011 << offset;
                        dmem_wdata[16*offset[1] +: 16] = rs2_v[15:0];
                    end
                    store_f3_sw: begin
                        dmem_wmask = 4'b1111;
                        dmem_wdata = rs2_v;
                    end
                    default: begin
                        dmem_wmask = '0;
                    end
                endcase
            end
            // load
            if (mem_re) begin
                dmem_req = 1'b1;
                case (funct3)
                    load_f3_lb, load_f3_lbu: dmem_rmask = 4'b0001 << offset;
                    load_f3_lh, load_f3_lhu: dmem_rmask = 4'b0011 << offset;
                    load_f3_lw:              dmem_rmask = 4'b1111;
                    default:                 dmem_rmask = '0;
                endcase
            end
        end
    end

endmodule

// ==== hw/mem_wb_top.sv ====
// memory back end top level with the ex/mem register, memory stage,
// data memory, mem/wb register and load alignment
`timescale 1ns/1ps
`include "mem_pipe_defines.svh"

module mem_wb_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                move,
    input  logic                in_valid,
    input  logic [4:0]          in_rd,
    input  logic [2:0]          in_funct3,
    input  logic                in_mem_we,
    input  logic                in_mem_re,
    input  logic                in_reg_we,
    input  logic [`MP_XLEN-1:0] in_alu_out,
    input  logic [`MP_XLEN-1:0] in_rs2_v,
    output logic                wb_valid,
    output logic                wb_we,
    output logic [4:0]          wb_rd,
    output logic [`MP_XLEN-1:0] wb_data
);
    import mem_pipe_pkg::*;

    ex_mem_payload_t ex_mem_d;
    ex_mem_payload_t ex_mem_q;
    logic            ex_mem_valid;
    mem_wb_payload_t mem_wb_d;
    mem_wb_payload_t mem_wb_q;
    logic            mem_wb_valid_d;
    logic            mem_wb_valid_q;

    logic                  dmem_req;
    logic [`MP_XLEN-1:0]   dmem_addr;
    logic [`MP_XLEN/8-1:0] dmem_wmask;
    logic [`MP_XLEN-1:0]   dmem_wdata;
    logic [`MP_XLEN-1:0]   dmem_rdata;

    assign ex_mem_d.rd      = in_rd;
    assign ex_mem_d.funct3  = in_funct3;
    assign ex_mem_d.mem_we  = in_mem_we;
    assign ex_mem_d.mem_re  = in_mem_re;
    assign ex_mem_d.reg_we  = in_reg_we;
    assign ex_mem_d.alu_out = in_alu_out;
    assign ex_mem_d.rs2_v   = in_rs2_v;

    stage_reg #(.payload_t(ex_mem_payload_t)) u_ex_mem (
        .clk        (clk),
        .rst        (rst),
        .move       (move),
        .in_valid   (in_valid),
        .in_payload (ex_mem_d),
        .out_valid  (ex_mem_valid),
        .out_payload(ex_mem_q)
    );

    // the sram has no read mask port
    mem_stage u_mem_stage (
        .move      (move),
        .in_valid  (ex_mem_valid),
        .funct3    (ex_mem_q.funct3),
        .mem_we    (ex_mem_q.mem_we),
        .mem_re    (ex_mem_q.mem_re),
        .alu_out   (ex_mem_q.alu_out),
        .rs2_v     (ex_mem_q.rs2_v),
        .dmem_req  (dmem_req),
        .dmem_addr (dmem_addr),
        .dmem_rmask(),
        .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata),
        .out_valid (mem_wb_valid_d)
    );

    dmem_sram u_dmem (
        .clk  (clk),
        .req  (dmem_req),
        .addr (dmem_addr),
        .wmask(dmem_wmask),
        .wdata(dmem_wdata),
        .rdata(dmem_rdata)
    );

    assign mem_wb_d.rd      = ex_mem_q.rd;
    assign mem_wb_d.funct3  = ex_mem_q.funct3;
    assign mem_wb_d.mem_re  = ex_mem_q.mem_re;
    assign mem_wb_d.reg_we  = ex_mem_q.reg_we;
    assign mem_wb_d.alu_out = ex_mem_q.alu_out;

    stage_reg #(.payload_t(mem_wb_payload_t)) u_mem_wb (
        .clk        (clk),
        .rst        (rst),
        .move       (move),
        .in_valid   (mem_wb_valid_d),
        .in_payload (mem_wb_d),
        .out_valid  (mem_wb_valid_q),
        .out_payload(mem_wb_q)
    );

    load_align u_load_align (
        .valid   (mem_wb_valid_q),
        .rd      (mem_wb_q.rd),
        .funct3  (mem_wb_q.funct3),
        .mem_re  (mem_wb_q.mem_re),
        .reg_we  (mem_wb_q.reg_we),
        .alu_out (mem_wb_q.alu_out),
        .rdata   (dmem_rdata),
        .wb_valid(wb_valid),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data)
    );

endmodule

// ==== hw/stage_reg.sv ====
// pipeline stage register for any payload type, with a valid bit
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     move,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (move) begin
            out_valid <= in_valid;
        end
    end

    // payload advances together with valid
    always_ff @(posedge clk) begin
        if (move) begin
            out_payload <= in_payload;
        end
    end

endmodule

// ==== mem_wb.f ====
+incdir+hw
hw/mem_pipe_pkg.sv
hw/stage_reg.sv
hw/mem_stage.sv
hw/dmem_sram.sv
hw/load_align.sv
hw/mem_wb_top.sv
dv/mem_wb_tb.sv
